// File: design/vertex_job_pkg.sv
//////////////////////////////
// shared widths, enums and records of the vertex job control unit
// imported by the RTL blocks and the testbench
//////////////////////////////

package vertex_job_pkg;

	// bus and record widths
	localparam int unsigned VERTEX_W   = 32;
	localparam int unsigned ADDR_W     = 32;
	localparam int unsigned DATA_W     = 32;
	localparam int unsigned WORD_BYTES = 4;

	// which vertex array a read targets
	typedef enum logic [1:0] {
		in_degree_arr,
		out_degree_arr,
		edges_idx_arr
	} vertex_array_e;

	// producer FSM states
	typedef enum logic [1:0] {
		fetch_idle,
		fetch_addr,
		fetch_data,
		fetch_push
	} fetch_state_e;

	// graph descriptor, sampled on start
	typedef struct packed {
		logic [VERTEX_W-1:0] num_vertices;
		logic [ADDR_W-1:0]   in_degree_base;
		logic [ADDR_W-1:0]   out_degree_base;
		logic [ADDR_W-1:0]   edges_idx_base;
	} graph_desc_t;

	// raw words in the buffer, swapped words on the job port
	typedef struct packed {
		logic [VERTEX_W-1:0] id;
		logic [DATA_W-1:0]   in_degree;
		logic [DATA_W-1:0]   out_degree;
		logic [DATA_W-1:0]   edges_idx;
	} vertex_rec_t;

	// AXI4-Lite read address and read data payloads
	typedef struct packed {
		logic [ADDR_W-1:0] araddr;
		logic [2:0]        arprot;
	} axil_ar_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic [1:0]        rresp;
	} axil_r_t;

endpackage

// File: design/vertex_fetch.sv
//////////////////////////////
// producer: AXI4-Lite read master that reads three array words per vertex
// and pushes one raw record per vertex into the job buffer
//////////////////////////////

`timescale 1ns/100ps

module vertex_fetch import vertex_job_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        start,
	input  graph_desc_t desc,
	output logic        busy,
	output logic        ar_valid,
	output axil_ar_t    ar,
	input  logic        ar_ready,
	input  logic        r_valid,
	input  axil_r_t     r,
	output logic        r_ready,
	output logic        push,
	output vertex_rec_t rec,
	input  logic        full,
	output logic        fetch_done
);

	fetch_state_e        state;
	vertex_array_e       sel;
	graph_desc_t         desc_q;
	logic [VERTEX_W-1:0] vertex_id;
	logic [VERTEX_W-1:0] remaining;
	logic [DATA_W-1:0]   words [0:2];
	logic [ADDR_W-1:0]   base;

	//////////////////////////////
	// read channel outputs
	//////////////////////////////

	// base address of the array being read
	always_comb begin
		case (sel)
			in_degree_arr:  base = desc_q.in_degree_base;
			out_degree_arr: base = desc_q.out_degree_base;
			default:        base = desc_q.edges_idx_base;
		endcase
	end

	// state and selector only change on a handshake, so ar holds while valid
	assign ar_valid  = (state == fetch_addr);
	assign ar.araddr = base + ADDR_W'(vertex_id * WORD_BYTES);
	// unprivileged, secure, data access
	assign ar.arprot = 3'b000;
	assign r_ready   = (state == fetch_data);

	assign busy = (state != fetch_idle);
	assign push = (state == fetch_push) && !full;

	// record is presented to the buffer while waiting in fetch_push
	assign rec.id         = vertex_id;
	assign rec.in_degree  = words[in_degree_arr];
	assign rec.out_degree = words[out_degree_arr];
	assign rec.edges_idx  = words[edges_idx_arr];

	//////////////////////////////
	// fetch FSM
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= fetch_idle;
			sel        <= in_degree_arr;
			vertex_id  <= '0;
			remaining  <= '0;
			fetch_done <= 1'b0;
		end else begin
			case (state)
				fetch_idle: begin
					if (start) begin
						vertex_id  <= '0;
						remaining  <= desc.num_vertices;
						sel        <= in_degree_arr;
						// empty graph finishes without any read
						fetch_done <= (desc.num_vertices == '0);
						if (desc.num_vertices != '0) begin
							state <= fetch_addr;
						end
					end
				end
				fetch_addr: begin
					if (ar_ready) begin
						state <= fetch_data;
					end
				end
				fetch_data: begin
					if (r_valid) begin
						if (sel == edges_idx_arr) begin
							state <= fetch_push;
						end else begin
							sel   <= (sel == in_degree_arr) ? out_degree_arr : edges_idx_arr;
							state <= fetch_addr;
						end
					end
				end
				fetch_push: begin
					// back-pressure point, hold the record until there is room
					if (!full) begin
						vertex_id <= vertex_id + 1'b1;
						remaining <= remaining - 1'b1;
						sel       <= in_degree_arr;
						if (remaining == VERTEX_W'(1)) begin
							fetch_done <= 1'b1;
							state      <= fetch_idle;
						end else begin
							state <= fetch_addr;
						end
					end
				end
				default: state <= fetch_idle;
			endcase
		end
	end

	// descriptor and returned words
	always_ff @(posedge clock) begin
		if (start && (state == fetch_idle)) begin
			desc_q <= desc;
		end
		if ((state == fetch_data) && r_valid) begin
			words[sel] <= r.rdata;
		end
	end

endmodule

// File: design/job_fifo.sv
//////////////////////////////
// circular buffer of raw vertex records between fetch and filter
// head word is shown without a pop
//////////////////////////////

`timescale 1ns/100ps

module job_fifo import vertex_job_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic        clock,
	input  logic        rstn,
	input  logic        push,
	input  vertex_rec_t din,
	output logic        full,
	input  logic        pop,
	output vertex_rec_t dout,
	output logic        empty
);

	localparam int AW = $clog2(FIFO_DEPTH);

	vertex_rec_t mem [0:FIFO_DEPTH-1];
	// extra msb tells a full buffer from an empty one
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        do_push;
	logic        do_pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// push while full and pop while empty are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign dout = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr[AW-1:0]] <= din;
		end
	end

endmodule

// File: design/job_filter.sv
//////////////////////////////
// consumer: byte-swaps buffered records, drops vertices without
// out-edges and offers the rest on the job port
//////////////////////////////

`timescale 1ns/100ps

module job_filter import vertex_job_pkg::*; (
	input  logic                clock,
	input  logic                rstn,
	input  logic                start,
	input  vertex_rec_t         head,
	input  logic                empty,
	output logic                pop,
	input  logic                fetch_done,
	output logic                job_valid,
	output vertex_rec_t         job,
	input  logic                job_ready,
	output logic [VERTEX_W-1:0] filtered_count,
	output logic                done
);

	vertex_rec_t swapped;
	logic        keep;

	// big-endian memory word to little-endian
	function automatic logic [DATA_W-1:0] swap_bytes(input logic [DATA_W-1:0] w);
		return {<<8{w}};
	endfunction

	assign swapped.id         = head.id;
	assign swapped.in_degree  = swap_bytes(head.in_degree);
	assign swapped.out_degree = swap_bytes(head.out_degree);
	assign swapped.edges_idx  = swap_bytes(head.edges_idx);

	assign keep = (swapped.out_degree != '0);

	// pop when the output register is free or drains this cycle
	assign pop = !empty && (!job_valid || job_ready);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_valid      <= 1'b0;
			filtered_count <= '0;
			done           <= 1'b0;
		end else begin
			if (pop) begin
				job_valid <= keep;
			end else if (job_ready) begin
				job_valid <= 1'b0;
			end
			if (start) begin
				filtered_count <= '0;
			end else if (pop && !keep) begin
				filtered_count <= filtered_count + 1'b1;
			end
			// held until the next accepted start
			if (start) begin
				done <= 1'b0;
			end else if (fetch_done && empty && !job_valid) begin
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (pop && keep) begin
			job <= swapped;
		end
	end

endmodule

// File: design/vertex_job_control.sv
//////////////////////////////
// vertex job control top: fetch, job buffer and filter in a row
//////////////////////////////

`timescale 1ns/100ps

module vertex_job_control import vertex_job_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                clock,
	input  logic                rstn,
	input  logic                start,
	input  graph_desc_t         desc,
	output logic                busy,
	output logic                ar_valid,
	output axil_ar_t            ar,
	input  logic                ar_ready,
	input  logic                r_valid,
	input  axil_r_t             r,
	output logic                r_ready,
	output logic                job_valid,
	output vertex_rec_t         job,
	input  logic                job_ready,
	output logic [VERTEX_W-1:0] filtered_count,
	output logic                done
);

	logic        start_ok;
	logic        push;
	logic        pop;
	logic        full;
	logic        empty;
	logic        fetch_done;
	vertex_rec_t rec;
	vertex_rec_t head;

	// a start during a running graph is ignored
	assign start_ok = start && !busy;

	vertex_fetch fetch_i (
		.clock      (clock),
		.rstn       (rstn),
		.start      (start_ok),
		.desc       (desc),
		.busy       (busy),
		.ar_valid   (ar_valid),
		.ar         (ar),
		.ar_ready   (ar_ready),
		.r_valid    (r_valid),
		.r          (r),
		.r_ready    (r_ready),
		.push       (push),
		.rec        (rec),
		.full       (full),
		.fetch_done (fetch_done)
	);

	job_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) fifo_i (
		.clock (clock),
		.rstn  (rstn),
		.push  (push),
		.din   (rec),
		.full  (full),
		.pop   (pop),
		.dout  (head),
		.empty (empty)
	);

	job_filter filter_i (
		.clock          (clock),
		.rstn           (rstn),
		.start          (start_ok),
		.head           (head),
		.empty          (empty),
		.pop            (pop),
		.fetch_done     (fetch_done),
		.job_valid      (job_valid),
		.job            (job),
		.job_ready      (job_ready),
		.filtered_count (filtered_count),
		.done           (done)
	);

endmodule

// File: sim/vertex_job_props.sv
//////////////////////////////
// bound checks on the AXI4-Lite read channels and the job port
//////////////////////////////

`timescale 1ns/100ps

module vertex_job_props import vertex_job_pkg::*; (
	input logic        clock,
	input logic        rstn,
	input logic        ar_valid,
	input axil_ar_t    ar,
	input logic        ar_ready,
	input logic        r_ready,
	input logic        job_valid,
	input vertex_rec_t job,
	input logic        job_ready
);

	// address holds until accepted
	ar_hold: assert property (@(posedge clock) disable iff (!rstn)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else $error("ar changed while waiting for ar_ready");

	// job holds until accepted
	job_hold: assert property (@(posedge clock) disable iff (!rstn)
		job_valid && !job_ready |=> job_valid && $stable(job))
		else $error("job changed while waiting for job_ready");

	// one read outstanding
	one_read: assert property (@(posedge clock) disable iff (!rstn)
		!(r_ready && ar_valid))
		else $error("r_ready and ar_valid high together");

endmodule

bind vertex_job_control vertex_job_props props_i (
	.clock     (clock),
	.rstn      (rstn),
	.ar_valid  (ar_valid),
	.ar        (ar),
	.ar_ready  (ar_ready),
	.r_ready   (r_ready),
	.job_valid (job_valid),
	.job       (job),
	.job_ready (job_ready)
);

// File: sim/tb_vertex_job_control.sv
//////////////////////////////
// testbench for the vertex job control unit, run from the project root
// AXI4-Lite memory model and tests come from the stim file
//////////////////////////////

`timescale 1ns/100ps

module tb_vertex_job_control import vertex_job_pkg::*; ();

	localparam int LONG_STALL = 120;
	localparam int HDR_WORDS  = 7;

	logic                clock     = 1'b0;
	logic                rstn      = 1'b0;
	logic                start     = 1'b0;
	graph_desc_t         desc      = '0;
	logic                ar_ready  = 1'b0;
	logic                r_valid   = 1'b0;
	axil_r_t             r         = '0;
	logic                job_ready = 1'b0;
	logic                busy;
	logic                ar_valid;
	axil_ar_t            ar;
	logic                r_ready;
	logic                job_valid;
	vertex_rec_t         job;
	logic [VERTEX_W-1:0] filtered_count;
	logic                done;

	logic [31:0]       stim [0:255];
	logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
	logic [ADDR_W-1:0] ar_log [$];
	vertex_rec_t       got_jobs [$];
	int unsigned       watch_cycles = 0;
	int                errors       = 0;
	int                tests_passed = 0;
	int                tests_failed = 0;
	logic              stall_mode   = 1'b0;
	int                ready_wait   = 0;
	int                ar_wait      = 0;
	int                r_wait       = 0;
	logic              rd_pending   = 1'b0;
	logic [ADDR_W-1:0] rd_addr      = '0;

	vertex_job_control #(
		.FIFO_DEPTH (4)
	) dut_i (
		.clock          (clock),
		.rstn           (rstn),
		.start          (start),
		.desc           (desc),
		.busy           (busy),
		.ar_valid       (ar_valid),
		.ar             (ar),
		.ar_ready       (ar_ready),
		.r_valid        (r_valid),
		.r              (r),
		.r_ready        (r_ready),
		.job_valid      (job_valid),
		.job            (job),
		.job_ready      (job_ready),
		.filtered_count (filtered_count),
		.done           (done)
	);

	always #10 clock = ~clock;

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp, input string msg);
		if (got !== exp) begin
			$display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	// memory words are big-endian
	function automatic logic [31:0] byte_reverse(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
		if (mem.exists(addr)) begin
			return mem[addr];
		end
		// unmapped fill
		return addr ^ 32'hc3a5_5a3c;
	endfunction

	//////////////////////////////
	// AXI4-Lite read slave
	//////////////////////////////

	// a ready or valid raised here transfers at the next rising edge
	always @(negedge clock) begin
		ar_ready = 1'b0;
		if (r_valid) begin
			r_valid    = 1'b0;
			rd_pending = 1'b0;
		end
		if (ar_valid && !rd_pending) begin
			if (ar_wait != 0) begin
				ar_wait--;
			end else begin
				ar_ready   = 1'b1;
				rd_pending = 1'b1;
				rd_addr    = ar.araddr;
				ar_log.push_back(ar.araddr);
				// plain unprivileged secure data access
				check_value(ar.arprot, 3'b000, "arprot of a read");
				ar_wait    = $urandom_range(3, 0);
				r_wait     = $urandom_range(3, 0);
			end
		end else if (rd_pending && r_ready) begin
			if (r_wait != 0) begin
				r_wait--;
			end else begin
				r.rdata = read_word(rd_addr);
				r.rresp = 2'b00;
				r_valid = 1'b1;
			end
		end
	end

	// job sink, stalls at random in stall mode
	always @(negedge clock) begin
		if (stall_mode && ready_wait > 0) begin
			ready_wait--;
			job_ready = 1'b0;
		end else begin
			job_ready = 1'b1;
		end
		if (job_valid && job_ready) begin
			got_jobs.push_back(job);
			if (stall_mode) begin
				ready_wait = $urandom_range(3, 0);
			end
		end
	end

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic run_test(input int t, input int unsigned p);
		graph_desc_t       d;
		graph_desc_t       bogus;
		vertex_rec_t       exp_jobs [$];
		vertex_rec_t       e;
		logic [ADDR_W-1:0] base;
		int unsigned       n;
		logic [31:0]       flags;
		int                errs_before;
		d            = {stim[p], stim[p+1], stim[p+2], stim[p+3]};
		n            = d.num_vertices;
		flags        = stim[p+4];
		errs_before  = errors;
		@(posedge clock);
		mem.delete();
		ar_log.delete();
		got_jobs.delete();
		stall_mode = flags[0];
		ready_wait = flags[0] ? LONG_STALL : 0;
		for (int i = 0; i < n; i++) begin
			mem[d.in_degree_base + 4 * i]  = stim[p + HDR_WORDS + 3 * i];
			mem[d.out_degree_base + 4 * i] = stim[p + HDR_WORDS + 3 * i + 1];
			mem[d.edges_idx_base + 4 * i]  = stim[p + HDR_WORDS + 3 * i + 2];
			e.id         = i;
			e.in_degree  = byte_reverse(stim[p + HDR_WORDS + 3 * i]);
			e.out_degree = byte_reverse(stim[p + HDR_WORDS + 3 * i + 1]);
			e.edges_idx  = byte_reverse(stim[p + HDR_WORDS + 3 * i + 2]);
			if (e.out_degree != 0) begin
				exp_jobs.push_back(e);
			end
		end
		@(negedge clock);
		desc  = d;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		if (flags[1]) begin
			// a second start with another graph must be ignored
			// sent once a vertex has been filtered, so a reset count would show
			while (filtered_count == 0) @(negedge clock);
			check_value(busy, 1'b1, "busy at second start");
			bogus = d;
			bogus.num_vertices   = n + 5;
			bogus.in_degree_base = d.in_degree_base + 32'h8000_0000;
			desc  = bogus;
			start = 1'b1;
			@(negedge clock);
			start = 1'b0;
			desc  = d;
		end
		while (!done) @(negedge clock);
		check_value(filtered_count, stim[p+6], $sformatf("test %0d filtered count", t));
		check_value(got_jobs.size(), stim[p+5], $sformatf("test %0d job count", t));
		for (int i = 0; i < got_jobs.size() && i < exp_jobs.size(); i++) begin
			check_value(got_jobs[i], exp_jobs[i], $sformatf("test %0d job %0d", t, i));
		end
		check_value(ar_log.size(), 3 * n, $sformatf("test %0d read count", t));
		for (int k = 0; k < ar_log.size(); k++) begin
			case (k % 3)
				0:       base = d.in_degree_base;
				1:       base = d.out_degree_base;
				default: base = d.edges_idx_base;
			endcase
			check_value(ar_log[k], base + 4 * (k / 3), $sformatf("test %0d read %0d address", t, k));
		end
		if (errors == errs_before) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
		$display("test %0d: %0d vertices, %0d jobs, %0d filtered, %s", t, n, got_jobs.size(),
			filtered_count, (errors == errs_before) ? "passed" : "failed");
	endtask

	initial begin
		int unsigned p;
		int unsigned total;
		void'($urandom(32'ha758_aec6));
		$readmemh("sim/vertex_stim.txt", stim);
		p     = 1;
		total = 0;
		for (int t = 0; t < stim[0]; t++) begin
			total += stim[p];
			p += HDR_WORDS + 3 * stim[p];
		end
		watch_cycles = total * 40 + 1000;
		repeat (10) @(negedge clock);
		rstn = 1'b1;
		p = 1;
		for (int t = 0; t < stim[0]; t++) begin
			run_test(t, p);
			p += HDR_WORDS + 3 * stim[p];
		end
		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (watch_cycles != 0);
		repeat (watch_cycles) @(posedge clock);
		$display("the run timed out after %0d cycles without finishing", watch_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: sim/vertex_stim.txt
// first word: number of tests; per test: num_vertices in_base out_base edges_base flags
// exp_jobs exp_filtered (flags bit0 stall job_ready, bit1 extra start), then per vertex: in out edges
00000004
00000004 00001000 00002000 00003000 00000000 00000003 00000001
02000000 03000000 00000000
01000000 00000000 03000000
00010000 01000000 03000000
05000000 02000000 04000000
00000000 00004000 00005000 00006000 00000000 00000000 00000000
0000000a 00010000 00011000 00012000 00000003 00000007 00000003
01000000 04000000 00000000
02000000 01000000 04000000
00000000 00000000 05000000
03000000 02000000 05000000
01000000 07000000 07000000
02000000 00000000 0e000000
04000000 01010000 0e000000
01000000 03000000 0f000000
00000000 00000000 12000000
05000000 02000000 12000000
00000003 00020000 00020100 00020200 00000002 00000002 00000001
0a000000 00000001 00000000
0b000000 00000000 01000000
0c000000 0000ff00 01000000

// File: project.f
design/vertex_job_pkg.sv
design/vertex_fetch.sv
design/job_fifo.sv
design/job_filter.sv
design/vertex_job_control.sv
sim/vertex_job_props.sv
sim/tb_vertex_job_control.sv

// File: run_sim.sh
#!/bin/sh
# build and run the vertex job control testbench with Verilator
cd "$(dirname "$0")" \
	&& verilator --binary --assert -Wno-fatal --top-module tb_vertex_job_control \
		-f project.f -o tb_sim \
	&& ./obj_dir/tb_sim 2>&1 | tee sim.log \
	&& ! grep -q "TEST FAILED" sim.log \
	&& grep -q "TEST OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
